// File: rv32i_types.sv
package rv32i_types;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // Instruction format views, most significant field first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // addi x0, x0, 0
    localparam word_t nop_word = 32'h0000_0013;

    localparam word_t reset_pc_default = 32'h0000_0000;

endpackage

// File: rv32i_ctrl.sv
package rv32i_ctrl;

    // ALU codes follow {funct7[5], funct3} so decode can pass them straight through
    localparam logic [3:0] alu_add   = 4'b0000;
    localparam logic [3:0] alu_sll   = 4'b0001;
    localparam logic [3:0] alu_slt   = 4'b0010;
    localparam logic [3:0] alu_sltu  = 4'b0011;
    localparam logic [3:0] alu_xor   = 4'b0100;
    localparam logic [3:0] alu_srl   = 4'b0101;
    localparam logic [3:0] alu_or    = 4'b0110;
    localparam logic [3:0] alu_and   = 4'b0111;
    localparam logic [3:0] alu_sub   = 4'b1000;
    localparam logic [3:0] alu_sra   = 4'b1101;
    localparam logic [3:0] alu_passb = 4'b1111;

    // Writeback source
    localparam logic [1:0] wb_alu  = 2'd0;
    localparam logic [1:0] wb_mem  = 2'd1;
    localparam logic [1:0] wb_link = 2'd2;

    // Load and store sizes
    localparam logic [2:0] f3_byte  = 3'b000;
    localparam logic [2:0] f3_half  = 3'b001;
    localparam logic [2:0] f3_word  = 3'b010;
    localparam logic [2:0] f3_byteu = 3'b100;

    // Branch conditions
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

endpackage

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage #(
    parameter rv32i_types::word_t reset_pc = rv32i_types::reset_pc_default
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               advance,
    input  logic               redirect,
    input  rv32i_types::word_t target,
    input  rv32i_types::word_t inst_rdata,
    output logic               inst_read,
    output rv32i_types::word_t inst_addr,
    output rv32i_types::word_t if_pc,
    output rv32i_types::word_t if_inst,
    output logic               if_valid
);
    import rv32i_types::*;

    word_t pc;

    // Always fetching, the pipeline only moves when the word is back
    assign inst_read = 1'b1;
    assign inst_addr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else if (advance) begin
            pc       <= redirect ? target : pc + 32'd4;
            if_valid <= !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if_pc   <= pc;
            if_inst <= redirect ? nop_word : inst_rdata;
        end
    end

    // Branch and jump targets from execute must keep the pc aligned
    assert property (@(posedge clk) disable iff (!arst_n) inst_addr[1:0] == 2'b00)
        else $error("fetch: misaligned inst_addr %h", inst_addr);

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               advance,
    input  logic               redirect,
    input  rv32i_types::word_t if_pc,
    input  rv32i_types::word_t if_inst,
    input  logic               if_valid,
    input  rv32i_types::word_t wb_data,
    input  logic [4:0]         wb_rd,
    input  logic               wb_en,
    output rv32i_types::word_t id_pc,
    output rv32i_types::word_t id_rs1_val,
    output rv32i_types::word_t id_rs2_val,
    output rv32i_types::word_t id_imm,
    output logic [4:0]         id_rd,
    output logic [3:0]         id_alu_op,
    output logic               id_use_imm,
    output logic               id_use_pc,
    output logic               id_branch,
    output logic               id_branch_ne,
    output logic               id_jump,
    output logic               id_mem_read,
    output logic               id_mem_write,
    output logic               id_reg_write,
    output logic               id_valid,
    output logic [2:0]         id_size,
    output logic [1:0]         id_wb_sel
);
    import rv32i_types::*;
    import rv32i_ctrl::*;

    instr_t     inst;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    word_t      rs1_val, rs2_val;
    word_t      regs [1:31];
    logic [3:0] alu_op;
    logic [1:0] wb_sel;
    logic       use_imm, use_pc, branch, jump, mem_read, mem_write, reg_write;
    logic       legal, valid_next;

    assign inst = if_inst;

    assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign imm_u = {inst.u.imm, 12'b0};
    assign imm_j = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b1;
        use_pc    = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wb_sel    = wb_alu;
        imm       = imm_i;
        legal     = 1'b1;
        case (inst.r.opcode)
            op_lui: begin
                alu_op    = alu_passb;
                imm       = imm_u;
                reg_write = 1'b1;
            end
            op_auipc: begin
                use_pc    = 1'b1;
                imm       = imm_u;
                reg_write = 1'b1;
            end
            op_jal: begin
                jump      = 1'b1;
                imm       = imm_j;
                wb_sel    = wb_link;
                reg_write = 1'b1;
            end
            op_branch: begin
                branch = 1'b1;
                imm    = imm_b;
                legal  = inst.b.funct3 inside {f3_beq, f3_bne};
            end
            op_load: begin
                mem_read  = 1'b1;
                wb_sel    = wb_mem;
                reg_write = 1'b1;
                legal     = inst.i.funct3 inside {f3_byte, f3_byteu, f3_word};
            end
            op_store: begin
                mem_write = 1'b1;
                imm       = imm_s;
                legal     = inst.s.funct3 inside {f3_byte, f3_half, f3_word};
            end
            op_imm: begin
                // Bit 30 only selects SRAI, for the other immediates it is data
                alu_op    = {inst.i.funct3 == 3'b101 && inst.r.funct7[5], inst.i.funct3};
                reg_write = 1'b1;
            end
            op_reg: begin
                alu_op    = {inst.r.funct7[5], inst.r.funct3};
                use_imm   = 1'b0;
                reg_write = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    assign valid_next = if_valid && legal && !redirect;

    // Writeback bypasses into a read of the same register
    assign rs1_val = (inst.r.rs1 == 5'd0) ? '0 :
                     (wb_en && wb_rd == inst.r.rs1) ? wb_data : regs[inst.r.rs1];
    assign rs2_val = (inst.r.rs2 == 5'd0) ? '0 :
                     (wb_en && wb_rd == inst.r.rs2) ? wb_data : regs[inst.r.rs2];

    always_ff @(posedge clk) begin
        if (advance && wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid     <= 1'b0;
            id_branch    <= 1'b0;
            id_jump      <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
        end else if (advance) begin
            id_valid     <= valid_next;
            id_branch    <= valid_next && branch;
            id_jump      <= valid_next && jump;
            id_mem_read  <= valid_next && mem_read;
            id_mem_write <= valid_next && mem_write;
            id_reg_write <= valid_next && reg_write && inst.r.rd != 5'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            id_pc        <= if_pc;
            id_rs1_val   <= rs1_val;
            id_rs2_val   <= rs2_val;
            id_imm       <= imm;
            id_rd        <= inst.r.rd;
            id_alu_op    <= alu_op;
            id_use_imm   <= use_imm;
            id_use_pc    <= use_pc;
            id_branch_ne <= inst.b.funct3 == f3_bne;
            id_size      <= inst.r.funct3;
            id_wb_sel    <= wb_sel;
        end
    end

    // x0 writes are dropped here, so none may reach writeback
    assert property (@(posedge clk) disable iff (!arst_n) wb_en |-> wb_rd != 5'd0)
        else $error("decode: write to x0 reached writeback");

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               advance,
    input  rv32i_types::word_t id_pc,
    input  rv32i_types::word_t id_rs1_val,
    input  rv32i_types::word_t id_rs2_val,
    input  rv32i_types::word_t id_imm,
    input  logic [4:0]         id_rd,
    input  logic [3:0]         id_alu_op,
    input  logic               id_use_imm,
    input  logic               id_use_pc,
    input  logic               id_branch,
    input  logic               id_branch_ne,
    input  logic               id_jump,
    input  logic               id_mem_read,
    input  logic               id_mem_write,
    input  logic               id_reg_write,
    input  logic               id_valid,
    input  logic [2:0]         id_size,
    input  logic [1:0]         id_wb_sel,
    output logic               redirect,
    output rv32i_types::word_t target,
    output rv32i_types::word_t ex_result,
    output rv32i_types::word_t ex_store_data,
    output rv32i_types::word_t ex_link,
    output logic [4:0]         ex_rd,
    output logic               ex_mem_read,
    output logic               ex_mem_write,
    output logic [2:0]         ex_size,
    output logic [1:0]         ex_wb_sel,
    output logic               ex_reg_write,
    output logic               ex_valid
);
    import rv32i_types::*;
    import rv32i_ctrl::*;

    word_t opa, opb, result;
    logic  taken;

    assign opa = id_use_pc ? id_pc : id_rs1_val;
    assign opb = id_use_imm ? id_imm : id_rs2_val;

    always_comb begin
        case (id_alu_op)
            alu_add:   result = opa + opb;
            alu_sub:   result = opa - opb;
            alu_sll:   result = opa << opb[4:0];
            alu_slt:   result = {31'b0, $signed(opa) < $signed(opb)};
            alu_sltu:  result = {31'b0, opa < opb};
            alu_xor:   result = opa ^ opb;
            alu_srl:   result = opa >> opb[4:0];
            alu_sra:   result = $signed(opa) >>> opb[4:0];
            alu_or:    result = opa | opb;
            alu_and:   result = opa & opb;
            alu_passb: result = opb;
            default:   result = opa + opb;
        endcase
    end

    assign taken    = id_branch && ((id_rs1_val == id_rs2_val) != id_branch_ne);
    assign redirect = id_valid && (id_jump || taken);
    assign target   = id_pc + id_imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (advance) begin
            ex_valid     <= id_valid;
            ex_mem_read  <= id_valid && id_mem_read;
            ex_mem_write <= id_valid && id_mem_write;
            ex_reg_write <= id_valid && id_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_result     <= result;
            ex_store_data <= id_rs2_val;
            ex_link       <= id_pc + 32'd4;
            ex_rd         <= id_rd;
            ex_size       <= id_size;
            ex_wb_sel     <= id_wb_sel;
        end
    end

    // A taken redirect leaves a bubble behind it in decode/execute
    assert property (@(posedge clk) disable iff (!arst_n) redirect && advance |=> !id_valid)
        else $error("execute: instruction after redirect was not squashed");

endmodule

// File: memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inst_resp,
    input  logic               data_resp,
    input  rv32i_types::word_t data_rdata,
    input  rv32i_types::word_t ex_result,
    input  rv32i_types::word_t ex_store_data,
    input  rv32i_types::word_t ex_link,
    input  logic [4:0]         ex_rd,
    input  logic               ex_mem_read,
    input  logic               ex_mem_write,
    input  logic [2:0]         ex_size,
    input  logic [1:0]         ex_wb_sel,
    input  logic               ex_reg_write,
    input  logic               ex_valid,
    output logic               advance,
    output logic               data_read,
    output logic               data_write,
    output logic [3:0]         data_mbe,
    output rv32i_types::word_t data_addr,
    output rv32i_types::word_t data_wdata,
    output rv32i_types::word_t wb_data,
    output logic [4:0]         wb_rd,
    output logic               wb_en
);
    import rv32i_types::*;
    import rv32i_ctrl::*;

    word_t      lane, load_val, wb_next;
    logic [1:0] off;

    assign off        = ex_result[1:0];
    assign data_read  = ex_valid && ex_mem_read;
    assign data_write = ex_valid && ex_mem_write;
    assign data_addr  = {ex_result[31:2], 2'b00};

    // Whole pipeline waits on the fetch and on any data access
    assign advance = inst_resp && (!(data_read || data_write) || data_resp);

    always_comb begin
        case (ex_size)
            f3_byte, f3_byteu: begin
                data_mbe   = 4'b0001 << off;
                data_wdata = {4{ex_store_data[7:0]}};
            end
            f3_half: begin
                data_mbe   = 4'b0011 << {off[1], 1'b0};
                data_wdata = {2{ex_store_data[15:0]}};
            end
            default: begin
                data_mbe   = 4'b1111;
                data_wdata = ex_store_data;
            end
        endcase
    end

    assign lane = data_rdata >> {off, 3'b000};

    always_comb begin
        case (ex_size)
            f3_byte:  load_val = {{24{lane[7]}}, lane[7:0]};
            f3_byteu: load_val = {24'b0, lane[7:0]};
            default:  load_val = data_rdata;
        endcase
    end

    always_comb begin
        case (ex_wb_sel)
            wb_mem:  wb_next = load_val;
            wb_link: wb_next = ex_link;
            default: wb_next = ex_result;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_en <= 1'b0;
        end else if (advance) begin
            wb_en <= ex_valid && ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_data <= wb_next;
            wb_rd   <= ex_rd;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(data_read && data_write))
        else $error("memory: read and write requested together");

endmodule

// File: cpu.sv
`timescale 1ns/100ps

module cpu #(
    parameter rv32i_types::word_t reset_pc = rv32i_types::reset_pc_default
) (
    input  logic               clk,
    input  logic               arst_n,
    output logic               inst_read,
    output rv32i_types::word_t inst_addr,
    input  rv32i_types::word_t inst_rdata,
    input  logic               inst_resp,
    output logic               data_read,
    output logic               data_write,
    output logic [3:0]         data_mbe,
    output rv32i_types::word_t data_addr,
    output rv32i_types::word_t data_wdata,
    input  rv32i_types::word_t data_rdata,
    input  logic               data_resp
);
    import rv32i_types::*;

    logic       advance, redirect;
    word_t      target;

    word_t      if_pc, if_inst;
    logic       if_valid;

    word_t      id_pc, id_rs1_val, id_rs2_val, id_imm;
    logic [4:0] id_rd;
    logic [3:0] id_alu_op;
    logic [2:0] id_size;
    logic [1:0] id_wb_sel;
    logic       id_use_imm, id_use_pc, id_branch, id_branch_ne, id_jump;
    logic       id_mem_read, id_mem_write, id_reg_write, id_valid;

    word_t      ex_result, ex_store_data, ex_link;
    logic [4:0] ex_rd;
    logic [2:0] ex_size;
    logic [1:0] ex_wb_sel;
    logic       ex_mem_read, ex_mem_write, ex_reg_write, ex_valid;

    word_t      wb_data;
    logic [4:0] wb_rd;
    logic       wb_en;

    fetch_stage #(.reset_pc(reset_pc)) fetch (
        .clk, .arst_n, .advance, .redirect, .target, .inst_rdata,
        .inst_read, .inst_addr, .if_pc, .if_inst, .if_valid
    );

    decode_stage decode (
        .clk, .arst_n, .advance, .redirect, .if_pc, .if_inst, .if_valid,
        .wb_data, .wb_rd, .wb_en,
        .id_pc, .id_rs1_val, .id_rs2_val, .id_imm, .id_rd, .id_alu_op,
        .id_use_imm, .id_use_pc, .id_branch, .id_branch_ne, .id_jump,
        .id_mem_read, .id_mem_write, .id_reg_write, .id_valid, .id_size, .id_wb_sel
    );

    execute_stage execute (
        .clk, .arst_n, .advance,
        .id_pc, .id_rs1_val, .id_rs2_val, .id_imm, .id_rd, .id_alu_op,
        .id_use_imm, .id_use_pc, .id_branch, .id_branch_ne, .id_jump,
        .id_mem_read, .id_mem_write, .id_reg_write, .id_valid, .id_size, .id_wb_sel,
        .redirect, .target, .ex_result, .ex_store_data, .ex_link, .ex_rd,
        .ex_mem_read, .ex_mem_write, .ex_size, .ex_wb_sel, .ex_reg_write, .ex_valid
    );

    memory_stage memory (
        .clk, .arst_n, .inst_resp, .data_resp, .data_rdata,
        .ex_result, .ex_store_data, .ex_link, .ex_rd, .ex_mem_read, .ex_mem_write,
        .ex_size, .ex_wb_sel, .ex_reg_write, .ex_valid,
        .advance, .data_read, .data_write, .data_mbe, .data_addr, .data_wdata,
        .wb_data, .wb_rd, .wb_en
    );

endmodule

// File: tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

    localparam int prog_len   = 60;
    localparam int n_stores   = 23;
    localparam int cycle_limit = prog_len * 4 * 5 + 200;
    localparam logic [31:0] nop = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        inst_read, inst_resp, data_read, data_write, data_resp;
    logic [31:0] inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;
    logic [3:0]  data_mbe;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [0:n_stores-1];
    logic [31:0] exp_data [0:n_stores-1];
    logic [3:0]  exp_mbe  [0:n_stores-1];

    logic [31:0] lfsr = 32'd99117;
    logic [31:0] inst_sig;
    logic [69:0] data_sig;
    int          store_idx = 0;
    int          cycles = 0;
    int          inst_wait, data_wait;
    logic        live, adv, started = 1'b0;

    cpu #(.reset_pc(32'h0000_0000)) UUT (
        .clk, .arst_n, .inst_read, .inst_addr, .inst_rdata, .inst_resp,
        .data_read, .data_write, .data_mbe, .data_addr, .data_wdata,
        .data_rdata, .data_resp
    );

    always #5 clk = ~clk;

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step for each bit of a wait
    task automatic draw_wait(output int w);
        logic [1:0] b;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_next(lfsr);
            b[k] = lfsr[0];
        end
        w = b;
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic expect_store(input int i, input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] m);
        exp_addr[i] = a;
        exp_data[i] = d;
        exp_mbe[i]  = m;
    endtask

    task automatic load_tables;
        imem[0]  = enc_i(-12'sd13, 0, 3'b000, 1, 7'b0010011);
        imem[1]  = enc_i(12'd5, 0, 3'b000, 2, 7'b0010011);
        imem[2]  = {20'h12345, 5'd3, 7'b0110111};
        imem[3]  = {20'h00001, 5'd4, 7'b0010111};
        imem[4]  = enc_i(12'h0FF, 1, 3'b100, 15, 7'b0010011);
        imem[5]  = enc_r(7'h20, 2, 1, 3'b000, 6);
        imem[6]  = enc_r(7'h00, 2, 1, 3'b111, 7);
        imem[7]  = enc_r(7'h00, 2, 1, 3'b110, 8);
        imem[8]  = enc_r(7'h00, 2, 1, 3'b100, 9);
        imem[9]  = enc_r(7'h00, 2, 1, 3'b010, 10);
        imem[10] = enc_r(7'h00, 2, 1, 3'b011, 11);
        imem[11] = enc_r(7'h00, 2, 2, 3'b001, 12);
        imem[12] = enc_r(7'h00, 2, 1, 3'b101, 13);
        imem[13] = enc_r(7'h20, 2, 1, 3'b101, 14);
        imem[14] = enc_r(7'h00, 2, 1, 3'b000, 5);
        imem[15] = enc_i(12'd6, 2, 3'b010, 16, 7'b0010011);
        imem[16] = enc_i(12'h402, 1, 3'b101, 17, 7'b0010011);
        imem[17] = enc_i(12'd3, 2, 3'b001, 18, 7'b0010011);
        for (int k = 0; k < 16; k++) begin
            imem[18 + k] = enc_s(12'(4 * k), 5'(3 + k), 3'b010);
        end
        imem[34] = enc_s(12'h041, 1, 3'b000);
        imem[35] = enc_s(12'h046, 3, 3'b001);
        imem[36] = enc_i(12'h041, 0, 3'b000, 19, 7'b0000011);
        imem[37] = enc_i(12'h041, 0, 3'b100, 20, 7'b0000011);
        imem[40] = enc_s(12'h048, 19, 3'b010);
        imem[41] = enc_s(12'h04C, 20, 3'b010);
        // Shadow stores of taken branches must never appear
        imem[42] = enc_b(13'd12, 2, 2, 3'b000);
        imem[43] = enc_s(12'h080, 2, 3'b010);
        imem[44] = enc_s(12'h084, 2, 3'b010);
        imem[45] = enc_b(13'd12, 2, 1, 3'b001);
        imem[46] = enc_s(12'h088, 2, 3'b010);
        imem[47] = enc_s(12'h08C, 2, 3'b010);
        // Not taken
        imem[48] = enc_b(13'd8, 2, 1, 3'b000);
        imem[49] = enc_s(12'h050, 2, 3'b010);
        imem[50] = enc_b(13'd8, 2, 2, 3'b001);
        imem[51] = enc_s(12'h054, 1, 3'b010);
        imem[52] = enc_j(21'd12, 21);
        imem[53] = enc_s(12'h090, 2, 3'b010);
        imem[54] = enc_s(12'h094, 2, 3'b010);
        imem[58] = enc_s(12'h058, 21, 3'b010);
        // Park in a self loop
        imem[59] = enc_j(21'd0, 0);

        expect_store(0,  32'h00, 32'h1234_5000, 4'hF);
        expect_store(1,  32'h04, 32'h0000_100C, 4'hF);
        expect_store(2,  32'h08, 32'hFFFF_FFF8, 4'hF);
        expect_store(3,  32'h0C, 32'hFFFF_FFEE, 4'hF);
        expect_store(4,  32'h10, 32'h0000_0001, 4'hF);
        expect_store(5,  32'h14, 32'hFFFF_FFF7, 4'hF);
        expect_store(6,  32'h18, 32'hFFFF_FFF6, 4'hF);
        expect_store(7,  32'h1C, 32'h0000_0001, 4'hF);
        expect_store(8,  32'h20, 32'h0000_0000, 4'hF);
        expect_store(9,  32'h24, 32'h0000_00A0, 4'hF);
        expect_store(10, 32'h28, 32'h07FF_FFFF, 4'hF);
        expect_store(11, 32'h2C, 32'hFFFF_FFFF, 4'hF);
        expect_store(12, 32'h30, 32'hFFFF_FF0C, 4'hF);
        expect_store(13, 32'h34, 32'h0000_0001, 4'hF);
        expect_store(14, 32'h38, 32'hFFFF_FFFC, 4'hF);
        expect_store(15, 32'h3C, 32'h0000_0028, 4'hF);
        expect_store(16, 32'h40, 32'hF3F3_F3F3, 4'b0010);
        expect_store(17, 32'h44, 32'h5000_5000, 4'b1100);
        expect_store(18, 32'h48, 32'hFFFF_FFF3, 4'hF);
        expect_store(19, 32'h4C, 32'h0000_00F3, 4'hF);
        expect_store(20, 32'h50, 32'h0000_0005, 4'hF);
        expect_store(21, 32'h54, 32'hFFFF_FFF3, 4'hF);
        expect_store(22, 32'h58, 32'h0000_00D4, 4'hF);
    endtask

    // Memory models sample at the edge and respond 1 ns later
    always @(posedge clk) begin
        live = arst_n;
        adv  = inst_resp && (!(data_read || data_write) || data_resp);
        cycles++;
        if (cycles > cycle_limit) begin
            fail_now("Timeout: the expected stores did not all arrive in time");
        end
        if (live && adv && data_write) begin
            assert (store_idx < n_stores) else fail_now("Store seen after the last expected one");
            check_value("data_addr", data_addr, exp_addr[store_idx]);
            check_value("data_wdata", data_wdata, exp_data[store_idx]);
            check_value("data_mbe", {28'b0, data_mbe}, {28'b0, exp_mbe[store_idx]});
            for (int b = 0; b < 4; b++) begin
                if (data_mbe[b]) begin
                    dmem[data_addr[7:2]][8*b +: 8] = data_wdata[8*b +: 8];
                end
            end
            store_idx++;
        end
        #1;
        if (!live) begin
            inst_resp = 1'b0;
            data_resp = 1'b0;
        end else begin
            if (!started || adv) begin
                draw_wait(inst_wait);
                draw_wait(data_wait);
                started = 1'b1;
            end else begin
                assert (inst_sig === inst_addr)
                    else fail_now("Instruction request changed before its response");
                assert (data_sig === {data_read, data_write, data_mbe, data_addr, data_wdata})
                    else fail_now("Data request changed before its response");
                if (inst_wait > 0) inst_wait--;
                if (data_wait > 0) data_wait--;
            end
            inst_sig   = inst_addr;
            data_sig   = {data_read, data_write, data_mbe, data_addr, data_wdata};
            inst_resp  = (inst_wait == 0);
            data_resp  = (data_wait == 0) && (data_read || data_write);
            inst_rdata = imem[inst_addr[7:2]];
            // Read data only comes back for a real read request
            data_rdata = data_read ? dmem[data_addr[7:2]] : 32'h0;
        end
    end

    initial begin
        arst_n     = 1'b0;
        inst_resp  = 1'b0;
        inst_rdata = '0;
        data_resp  = 1'b0;
        data_rdata = '0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = nop;
            dmem[i] = 32'hA500_0000 ^ (i * 32'h0001_0203);
        end
        load_tables();

        repeat (16) begin
            @(negedge clk);
            assert (!data_read && !data_write && inst_read)
                else fail_now("Port controls wrong during reset");
            check_value("inst_addr", inst_addr, 32'h0);
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        assert (!data_read && !data_write && inst_read)
            else fail_now("Port controls wrong right after reset");
        check_value("inst_addr", inst_addr, 32'h0);

        wait (store_idx == n_stores);
        // Let the self loop spin so a stray store would still show up
        repeat (40) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: all.f
rv32i_types.sv
rv32i_ctrl.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cpu
FLIST     := all.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
